//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module viper_cpu_tb -f files.f

sim:
	verilator --binary --timing --assert --top-module viper_cpu_tb -f files.f \
		-Mdir obj_dir -o viper_sim
	./obj_dir/viper_sim | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/bus_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "viper_consts.svh"

module bus_sequencer
	import viper_pkg::*;
(
	input  wire logic          clock,
	input  wire logic          reset,
	input  wire word_t         datai,
	input  wire word_t         pc,
	input  wire word_t         index1,
	input  wire word_t         index2,
	input  wire word_t         src_value,
	input  wire addr_t         tail,
	input  wire operand_mode_t mode,
	input  wire logic          needs_read,
	input  wire logic          is_store,
	output word_t              instr,
	output word_t              operand,
	output logic               exec,
	output addr_t              addr,
	output logic               rd,
	output logic               wr,
	output word_t              datao
);

	seq_state_t state;
	addr_t      eff_addr;

	// indexed modes wrap inside the 20-bit address space
	always_comb begin
		case (mode)
			mode_index1: eff_addr = tail + index1[`VIPER_ADDR_W-1:0];
			mode_index2: eff_addr = tail + index2[`VIPER_ADDR_W-1:0];
			default: eff_addr = tail;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
			addr <= '0;
			rd <= 1'b0;
			wr <= 1'b0;
			datao <= '0;
		end else begin
			rd <= 1'b0;
			wr <= 1'b0;
			case (state)
				st_fetch: begin
					addr <= pc[`VIPER_ADDR_W-1:0];
					rd <= 1'b1;
					state <= st_decode;
				end
				st_decode: begin
					state <= st_access;
				end
				st_access: begin
					addr <= eff_addr;
					rd <= needs_read;
					wr <= is_store;
					if (is_store) begin
						datao <= src_value;
					end
					state <= st_execute;
				end
				default: begin
					state <= st_fetch;
				end
			endcase
		end
	end

	// the instruction word arrives while the fetch read is on the bus
	always_ff @(posedge clock) begin
		if (state == st_decode) begin
			instr <= datai;
		end
	end

	// memory is combinational, so the operand is valid during execute
	assign operand = needs_read ? datai : word_t'(tail);
	assign exec = (state == st_execute);

	a_rd_wr_excl: assert property (
		@(posedge clock) disable iff (reset)
		!(rd && wr)
	);

	a_wr_after_access: assert property (
		@(posedge clock) disable iff (reset)
		wr |-> $past(state) == st_access
	);

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "viper_consts.svh"

module exec_unit
	import viper_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     exec,
	input  wire logic     is_compare,
	input  wire func_op_t func,
	input  wire dest_t    dest,
	input  wire word_t    src_value,
	input  wire word_t    operand,
	output logic          wr_en,
	output reg_sel_t      wr_sel,
	output word_t         wr_value,
	output logic          push,
	output logic          flag
);

	logic [2:0] cmp_code;
	logic       cmp_or;
	logic       cmp_valid;
	logic       less;
	logic       greater;
	logic       equal;
	logic       relation;
	logic       writes_reg;
	logic       dest_ok;
	word_t      sum;
	word_t      diff;

	// low three bits pick the relation, bit 3 accumulates into the flag
	assign cmp_code = func[2:0];
	assign cmp_or = func[3];
	assign cmp_valid = (cmp_code < 3'd6);

	assign less = $signed(src_value) < $signed(operand);
	assign greater = $signed(src_value) > $signed(operand);
	assign equal = (src_value == operand);

	always_comb begin
		case (cmp_code)
			3'd0: relation = less;
			3'd1: relation = !less;
			3'd2: relation = equal;
			3'd3: relation = !equal;
			3'd4: relation = !greater;
			default: relation = greater;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			flag <= 1'b0;
		end else if (exec && is_compare && cmp_valid) begin
			flag <= relation || (cmp_or && flag);
		end
	end

	assign sum = src_value + operand;
	assign diff = src_value - operand;

	always_comb begin
		case (func)
			op_neg: wr_value = '0 - operand;
			op_add_a, op_add_b, op_add_c, op_add_d:
				wr_value = word_t'(sum[`VIPER_RESULT_W-1:0]);
			op_sub_a, op_sub_b, op_sub_c, op_sub_d:
				wr_value = word_t'(diff[`VIPER_RESULT_W-1:0]);
			default: wr_value = operand;
		endcase
	end

	// push, shift and the no-op codes leave the write port idle
	assign writes_reg = !is_compare && !(func inside {op_push, op_shift, op_nop_a,
		op_nop_b, op_nop_c});

	always_comb begin
		case (dest)
			dest_r0, dest_r1, dest_r2, dest_r3: dest_ok = 1'b1;
			dest_pc_if_set: dest_ok = flag;
			dest_pc_if_clear: dest_ok = !flag;
			default: dest_ok = 1'b0;
		endcase
	end

	// conditional destinations all target the program counter
	assign wr_sel = dest[2] ? reg_sel_t'(2'd3) : reg_sel_t'(dest[1:0]);
	assign wr_en = writes_reg && dest_ok;
	assign push = !is_compare && (func == op_push) && (dest != dest_store);

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "viper_consts.svh"

module instr_decoder
	import viper_pkg::*;
(
	input  wire word_t     instr,
	output reg_sel_t       src_sel,
	output operand_mode_t  mode,
	output dest_t          dest,
	output logic           is_compare,
	output func_op_t       func,
	output addr_t          tail,
	output logic           needs_read,
	output logic           is_store
);

	// bit 31 is ignored, negative words decode like their low bits
	assign src_sel = reg_sel_t'(instr[`VIPER_SRC_LSB +: `VIPER_SRC_W]);
	assign mode = operand_mode_t'(instr[`VIPER_MODE_LSB +: `VIPER_MODE_W]);
	assign dest = dest_t'(instr[`VIPER_DEST_LSB +: `VIPER_DEST_W]);
	assign is_compare = instr[`VIPER_CLASS_BIT];
	assign func = func_op_t'(instr[`VIPER_FUNC_LSB +: `VIPER_FUNC_W]);

	// the tail overlaps the low function bit
	assign tail = instr[`VIPER_ADDR_W-1:0];

	// compares have no destination, so they never store
	assign is_store = !is_compare && (dest == dest_store);

	// immediate operands come from the tail, everything else from memory
	assign needs_read = (mode != mode_imm) && !is_store;

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "viper_consts.svh"

module register_file
	import viper_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     exec,
	input  wire reg_sel_t src_sel,
	output word_t         src_value,
	output word_t         pc,
	output word_t         index1,
	output word_t         index2,
	input  wire logic     wr_en,
	input  wire reg_sel_t wr_sel,
	input  wire word_t    wr_value,
	input  wire logic     push,
	input  wire word_t    push_target
);

	word_t reg0;
	word_t reg1;
	word_t reg2;
	word_t reg3;
	word_t pc_next;

	// register 3 is the program counter
	assign pc_next = word_t'(reg3[`VIPER_PC_KEEP-1:0]) + word_t'(`VIPER_PC_STEP);

	assign pc = reg3;
	assign index1 = reg1;
	assign index2 = reg2;

	// the source sees the counter already advanced for this instruction
	always_comb begin
		case (src_sel)
			2'd0: src_value = reg0;
			2'd1: src_value = reg1;
			2'd2: src_value = reg2;
			default: src_value = pc_next;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			reg0 <= '0;
			reg1 <= '0;
			reg2 <= '0;
			reg3 <= '0;
		end else if (exec) begin
			reg3 <= pc_next;
			if (push) begin
				// call, the return address lands in register 2
				reg2 <= pc_next;
				reg3 <= push_target;
			end else if (wr_en) begin
				case (wr_sel)
					2'd0: reg0 <= wr_value;
					2'd1: reg1 <= wr_value;
					2'd2: reg2 <= wr_value;
					default: reg3 <= wr_value;
				endcase
			end
		end
	end

	a_single_write: assert property (
		@(posedge clock) disable iff (reset)
		exec |-> !(wr_en && push)
	);

endmodule

`default_nettype wire

//--- design/viper_consts.svh
`ifndef VIPER_CONSTS_SVH
`define VIPER_CONSTS_SVH

// bus and register widths
`define VIPER_DATA_W 32
`define VIPER_ADDR_W 20

// add and subtract keep only the low bits of the result
`define VIPER_RESULT_W 30

// the program counter wraps at 2^29 before it steps
`define VIPER_PC_STEP 8
`define VIPER_PC_KEEP 29

// instruction word layout, tail is the low address-width bits
`define VIPER_SRC_LSB 29
`define VIPER_SRC_W 2
`define VIPER_MODE_LSB 27
`define VIPER_MODE_W 2
`define VIPER_DEST_LSB 24
`define VIPER_DEST_W 3
`define VIPER_CLASS_BIT 23
`define VIPER_FUNC_LSB 19
`define VIPER_FUNC_W 4

`endif

//--- design/viper_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module viper_cpu
	import viper_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire word_t datai,
	output addr_t      addr,
	output logic       rd,
	output logic       wr,
	output word_t      datao
);

	word_t         instr;
	word_t         operand;
	logic          exec;
	word_t         pc;
	word_t         index1;
	word_t         index2;
	word_t         src_value;
	reg_sel_t      src_sel;
	operand_mode_t mode;
	dest_t         dest;
	logic          is_compare;
	func_op_t      func;
	addr_t         tail;
	logic          needs_read;
	logic          is_store;
	logic          wr_en;
	reg_sel_t      wr_sel;
	word_t         wr_value;
	logic          push;

	bus_sequencer bus_sequencer_inst (
		.clock(clock), .reset(reset), .datai(datai), .pc(pc),
		.index1(index1), .index2(index2), .src_value(src_value), .tail(tail),
		.mode(mode), .needs_read(needs_read), .is_store(is_store),
		.instr(instr), .operand(operand), .exec(exec),
		.addr(addr), .rd(rd), .wr(wr), .datao(datao)
	);

	instr_decoder instr_decoder_inst (
		.instr(instr), .src_sel(src_sel), .mode(mode), .dest(dest),
		.is_compare(is_compare), .func(func), .tail(tail),
		.needs_read(needs_read), .is_store(is_store)
	);

	register_file register_file_inst (
		.clock(clock), .reset(reset), .exec(exec), .src_sel(src_sel),
		.src_value(src_value), .pc(pc), .index1(index1), .index2(index2),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_value(wr_value),
		.push(push), .push_target(operand)
	);

	// the flag stays internal, only conditional jumps observe it
	exec_unit exec_unit_inst (
		.clock(clock), .reset(reset), .exec(exec), .is_compare(is_compare),
		.func(func), .dest(dest), .src_value(src_value), .operand(operand),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_value(wr_value), .push(push),
		.flag()
	);

endmodule

`default_nettype wire

//--- design/viper_pkg.sv
`default_nettype none

`include "viper_consts.svh"

package viper_pkg;

	typedef logic [`VIPER_DATA_W-1:0] word_t;
	typedef logic [`VIPER_ADDR_W-1:0] addr_t;
	typedef logic [`VIPER_SRC_W-1:0] reg_sel_t;

	// one state per bus cycle of an instruction
	typedef enum logic [1:0] {
		st_fetch   = 2'd0,
		st_decode  = 2'd1,
		st_access  = 2'd2,
		st_execute = 2'd3
	} seq_state_t;

	typedef enum logic [`VIPER_MODE_W-1:0] {
		mode_imm    = 2'd0,
		mode_direct = 2'd1,
		mode_index1 = 2'd2,
		mode_index2 = 2'd3
	} operand_mode_t;

	// codes for the arithmetic class, compares reuse the same field
	typedef enum logic [`VIPER_FUNC_W-1:0] {
		op_neg    = 4'd0,
		op_push   = 4'd1,
		op_load_a = 4'd2,
		op_load_b = 4'd3,
		op_add_a  = 4'd4,
		op_add_b  = 4'd5,
		op_sub_a  = 4'd6,
		op_sub_b  = 4'd7,
		op_add_c  = 4'd8,
		op_sub_c  = 4'd9,
		op_add_d  = 4'd10,
		op_sub_d  = 4'd11,
		op_shift  = 4'd12,
		op_nop_a  = 4'd13,
		op_nop_b  = 4'd14,
		op_nop_c  = 4'd15
	} func_op_t;

	typedef enum logic [`VIPER_DEST_W-1:0] {
		dest_r0          = 3'd0,
		dest_r1          = 3'd1,
		dest_r2          = 3'd2,
		dest_r3          = 3'd3,
		dest_pc_if_set   = 3'd4,
		dest_pc_if_clear = 3'd5,
		dest_none        = 3'd6,
		dest_store       = 3'd7
	} dest_t;

endpackage

`default_nettype wire

//--- dv/viper_cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "viper_consts.svh"

module viper_cpu_tb
	import viper_pkg::*;
();

	localparam int N_RESET = 6;
	localparam int N_LOAD = 7;
	localparam int N_ARITH = 35;
	localparam int N_CMP = 48;
	localparam int N_PUSH = 5;
	localparam int N_TESTS = 5;
	localparam int TOTAL_INSTR = N_RESET + N_LOAD + N_ARITH + N_CMP + N_PUSH;
	localparam word_t RESULT_MASK = word_t'((64'd1 << `VIPER_RESULT_W) - 64'd1);

	logic   clock;
	logic   reset = 1'b1;
	word_t  datai = '0;
	addr_t  addr;
	logic   rd;
	logic   wr;
	word_t  datao;
	word_t  mem [addr_t];
	word_t  m_reg [4];
	logic   m_flag;
	logic   exp_rd;
	logic   exp_wr;
	addr_t  exp_addr;
	word_t  exp_data;
	addr_t  store_addr [$];
	int     cyc;
	int     target = 0;
	int     done_instr = 0;
	int     err_count = 0;
	int     check_count = 0;
	integer seed = 32'h9643_8bed;

	viper_cpu viper_cpu_inst (
		.clock(clock), .reset(reset), .datai(datai),
		.addr(addr), .rd(rd), .wr(wr), .datao(datao)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// unwritten locations return a word built from the full address
	function automatic word_t mem_word(input addr_t a);
		if (mem.exists(a))
			return mem[a];
		return {a[11:0] ^ 12'h5a3, a};
	endfunction

	always @(rd or addr) begin
		datai = rd ? mem_word(addr) : '0;
	end

	function automatic word_t encode(input logic [1:0] src, input logic [1:0] mode,
		input logic [2:0] dest, input logic cmp, input logic [3:0] fn, input logic [18:0] tail);
		return {1'b0, src, mode, dest, cmp, fn, tail};
	endfunction

	task automatic put_slot(input int slot, input word_t w);
		mem[addr_t'(slot * `VIPER_PC_STEP)] = w;
	endtask

	// steps the model through one instruction and predicts its bus access
	function automatic void step_model(input word_t instr);
		logic [1:0] src;
		logic [1:0] mode;
		logic [2:0] dest;
		logic       cmp;
		logic [3:0] fn;
		addr_t      tail;
		word_t      pc_adv;
		word_t      srcv;
		word_t      opnd;
		word_t      result;
		logic       rel;
		src = instr[30:29];
		mode = instr[28:27];
		dest = instr[26:24];
		cmp = instr[23];
		fn = instr[22:19];
		tail = instr[19:0];
		pc_adv = {3'b000, m_reg[3][28:0]} + word_t'(`VIPER_PC_STEP);
		srcv = (src == 2'd3) ? pc_adv : m_reg[src];
		case (mode)
			2'd2: exp_addr = tail + m_reg[1][19:0];
			2'd3: exp_addr = tail + m_reg[2][19:0];
			default: exp_addr = tail;
		endcase
		exp_wr = !cmp && (dest == 3'd7);
		exp_rd = (mode != 2'd0) && !exp_wr;
		exp_data = srcv;
		opnd = exp_rd ? mem_word(exp_addr) : word_t'(tail);
		m_reg[3] = pc_adv;
		if (cmp) begin
			case (fn[2:0])
				3'd0: rel = $signed(srcv) < $signed(opnd);
				3'd1: rel = $signed(srcv) >= $signed(opnd);
				3'd2: rel = (srcv == opnd);
				3'd3: rel = (srcv != opnd);
				3'd4: rel = $signed(srcv) <= $signed(opnd);
				default: rel = $signed(srcv) > $signed(opnd);
			endcase
			if (fn[2:0] < 3'd6)
				m_flag = rel || (fn[3] && m_flag);
		end else if (fn == 4'd1) begin
			if (!exp_wr) begin
				m_reg[2] = pc_adv;
				m_reg[3] = opnd;
			end
		end else if (fn < 4'd12) begin
			case (fn)
				4'd0: result = word_t'(0) - opnd;
				4'd2, 4'd3: result = opnd;
				4'd6, 4'd7, 4'd9, 4'd11: result = (srcv - opnd) & RESULT_MASK;
				default: result = (srcv + opnd) & RESULT_MASK;
			endcase
			if (dest < 3'd4)
				m_reg[dest[1:0]] = result;
			else if ((dest == 3'd4 && m_flag) || (dest == 3'd5 && !m_flag))
				m_reg[3] = result;
		end
	endfunction

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		check_count = check_count + 1;
		if (got !== exp) begin
			err_count = err_count + 1;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// bus outputs are compared in the middle of each cycle
	always @(negedge clock) begin
		if (reset) begin
			cyc = 0;
			done_instr = 0;
			m_reg = '{default: '0};
			m_flag = 1'b0;
		end else if (done_instr < target) begin
			if (cyc > 0 && (cyc - 1) % 4 == 0) begin
				check_strobe("rd", rd, 1'b1);
				check_strobe("wr", wr, 1'b0);
				check_addr("fetch addr", addr, addr_t'(m_reg[3]));
				step_model(mem_word(addr_t'(m_reg[3])));
			end else if (cyc > 0 && (cyc - 1) % 4 == 2) begin
				check_strobe("rd", rd, exp_rd);
				check_strobe("wr", wr, exp_wr);
				if (exp_rd || exp_wr)
					check_addr("access addr", addr, exp_addr);
				if (exp_wr)
					check_word("datao", datao, exp_data);
				if (wr)
					store_addr.push_back(addr);
			end else begin
				check_strobe("rd", rd, 1'b0);
				check_strobe("wr", wr, 1'b0);
				// the first cycle after reset still shows the reset values
				if (cyc == 0) begin
					check_addr("reset addr", addr, '0);
					check_word("reset datao", datao, '0);
				end
			end
			if (cyc > 0 && (cyc - 1) % 4 == 3)
				done_instr = done_instr + 1;
			cyc = cyc + 1;
		end
	end

	task automatic hold_reset();
		@(posedge clock);
		reset <= 1'b1;
		target = 0;
		mem.delete();
		store_addr.delete();
	endtask

	task automatic run_program(input string name, input int count);
		int errs_before;
		errs_before = err_count;
		repeat (8) @(posedge clock);
		target = count;
		reset <= 1'b0;
		wait (done_instr == count);
		$display("%s: %0d instructions, %0d stores, %0d errors", name, count,
			store_addr.size(), err_count - errs_before);
	endtask

	initial begin
		int         i;
		int         k;
		int         m;
		int         s;
		logic [3:0] fn;
		logic [3:0] arith_ops [4];
		word_t      a;
		word_t      b;
		logic [18:0] ta;
		logic [18:0] tb;
		arith_ops = '{op_add_a, op_sub_a, op_neg, op_add_c};

		hold_reset();
		for (i = 0; i < N_RESET; i++)
			put_slot(i, encode(2'd0, mode_imm, dest_none, 1'b0, op_nop_a, 19'(i)));
		run_program("reset and fetch", N_RESET);

		hold_reset();
		put_slot(0, encode(2'd0, mode_imm, dest_r0, 1'b0, op_load_a, 19'($random(seed))));
		put_slot(1, encode(2'd0, mode_imm, dest_r1, 1'b0, op_load_a, 19'h00100));
		put_slot(2, encode(2'd0, mode_imm, dest_r2, 1'b0, op_load_a, 19'h00444));
		put_slot(3, encode(2'd0, mode_direct, dest_store, 1'b0, op_load_a, 19'h07000));
		put_slot(4, encode(2'd1, mode_index1, dest_store, 1'b0, op_load_a, 19'h07010));
		put_slot(5, encode(2'd2, mode_index2, dest_store, 1'b0, op_load_a, 19'h07020));
		put_slot(6, encode(2'd3, mode_imm, dest_store, 1'b0, op_load_a, 19'h07030));
		run_program("load and store", N_LOAD);

		hold_reset();
		for (i = 0; i < 256; i++)
			mem[20'h40000 + addr_t'(i)] = $random(seed);
		put_slot(0, encode(2'd0, mode_imm, dest_r0, 1'b0, op_load_a, 19'($random(seed))));
		put_slot(1, encode(2'd0, mode_imm, dest_r1, 1'b0, op_load_a, 19'h00010));
		put_slot(2, encode(2'd0, mode_imm, dest_r2, 1'b0, op_load_a, 19'h00024));
		s = 3;
		for (m = 0; m < 4; m++) begin
			for (k = 0; k < 4; k++) begin
				put_slot(s, encode(2'd0, 2'(m), dest_r0, 1'b0, arith_ops[k],
					19'h40000 + 19'(s)));
				put_slot(s + 1, encode(2'd0, mode_direct, dest_store, 1'b0, op_load_a,
					19'h01000 + 19'(s)));
				s = s + 2;
			end
		end
		run_program("arithmetic", N_ARITH);

		// either path through a block runs four instructions
		hold_reset();
		for (k = 0; k < 12; k++) begin
			s = k * 5;
			fn = (k < 6) ? 4'(k) : 4'(k + 2);
			ta = 19'h50000 + 19'(2 * k);
			tb = ta + 19'd1;
			a = $random(seed);
			b = (k % 3 == 0) ? a : $random(seed);
			mem[{1'b0, ta}] = a;
			mem[{fn[0], tb}] = b;
			put_slot(s, encode(2'd0, mode_direct, dest_r0, 1'b0, op_load_a, ta));
			put_slot(s + 1, encode(2'd0, mode_direct, dest_none, 1'b1, fn, tb));
			put_slot(s + 2, encode(2'd0, mode_imm,
				(k % 2 == 1) ? dest_pc_if_clear : dest_pc_if_set, 1'b0, op_load_a,
				19'((s + 4) * `VIPER_PC_STEP)));
			put_slot(s + 3, encode(2'd0, mode_imm, dest_r3, 1'b0, op_load_a,
				19'((s + 5) * `VIPER_PC_STEP)));
			put_slot(s + 4, encode(2'd0, mode_imm, dest_none, 1'b0, op_nop_a, 19'd0));
		end
		run_program("compare and branch", N_CMP);

		// the odd push code sets tail bit 19, so the call lands at 20'h80200
		hold_reset();
		put_slot(0, encode(2'd0, mode_imm, dest_none, 1'b0, op_nop_a, 19'd0));
		put_slot(1, encode(2'd0, mode_imm, dest_r0, 1'b0, op_push, 19'h00200));
		mem[20'h80200] = encode(2'd2, mode_direct, dest_store, 1'b0, op_load_a, 19'h03000);
		mem[20'h80208] = encode(2'd3, mode_direct, dest_store, 1'b0, op_load_a, 19'h03008);
		mem[20'h80210] = encode(2'd0, mode_index2, dest_store, 1'b0, op_load_a, 19'h03000);
		run_program("push and return", N_PUSH);

		$display("tests %0d, checks %0d, errors %0d", N_TESTS, check_count, err_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (TOTAL_INSTR * 4 + N_TESTS * 12 + 100) @(posedge clock);
		$display("watchdog expired before all programs finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/viper_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/exec_unit.sv
design/bus_sequencer.sv
design/viper_cpu.sv
dv/viper_cpu_tb.sv
